//--- perf_cfg.svh
/* Performance monitor configuration
   counter count, commit ports, data widths and CSR base addresses */
`ifndef PERF_CFG_SVH
`define PERF_CFG_SVH

// counter geometry
`define PERF_NUM_CNT    6   // programmable counters
`define PERF_FIRST_CNT  3   // arch number of the first one, also its mcountinhibit bit
`define PERF_NR_COMMIT  2   // commit ports

// datapath widths
`define PERF_XLEN       32  // CSR data port
`define PERF_CNT_W      64  // full counter

// ---------------------------------------------------------------------------
// CSR map, counter 3 is the base of each range
// ---------------------------------------------------------------------------
`define CSR_MHPMCOUNTER3   12'hB03
`define CSR_MHPMCOUNTER3H  12'hB83
`define CSR_MHPMEVENT3     12'h323

`endif // PERF_CFG_SVH

//--- perf_event_pkg.sv
/* Event encoding for the performance monitor
   selector codes and commit functional-unit codes */
`default_nettype none

package perf_event_pkg;

  // selector codes, anything not listed counts nothing
  typedef enum logic [4:0] {
    EV_NONE        = 5'd0,
    EV_ICACHE_MISS = 5'd1,
    EV_DCACHE_MISS = 5'd2,
    EV_ITLB_MISS   = 5'd3,
    EV_DTLB_MISS   = 5'd4,
    EV_LOAD        = 5'd5,   // committed load
    EV_STORE       = 5'd6,   // committed store
    EV_EXCEPTION   = 5'd7,
    EV_ERET        = 5'd8,
    EV_BRANCH      = 5'd9,   // committed branch
    EV_MISPREDICT  = 5'd10,
    EV_SB_FULL     = 5'd14,
    EV_IF_EMPTY    = 5'd15,
    EV_INT_OP      = 5'd20,  // alu or mult
    EV_STALL_ISSUE = 5'd22
  } event_sel_e;

  // functional unit of a committing instruction
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    LOAD      = 3'd1,
    STORE     = 3'd2,
    ALU       = 3'd3,
    CTRL_FLOW = 3'd4,
    MULT      = 3'd5
  } fu_t;

endpackage

`default_nettype wire

//--- perf_csr_pkg.sv
/* CSR side types for the performance monitor
   address, data word, counter value and register decode */
`default_nettype none

`include "perf_cfg.svh"

package perf_csr_pkg;

  typedef logic [11:0]              csr_addr_t;
  typedef logic [`PERF_XLEN-1:0]    csr_data_t;
  typedef logic [`PERF_CNT_W-1:0]   cnt_t;
  typedef logic [2:0]               cnt_idx_t;   // 0..5 maps to counter 3..8

  // which register an address hits
  typedef enum logic [1:0] {
    REG_NONE   = 2'd0,
    REG_CNT_LO = 2'd1,  // mhpmcounterN
    REG_CNT_HI = 2'd2,  // mhpmcounterNh
    REG_EVENT  = 2'd3   // mhpmeventN
  } reg_kind_e;

endpackage

`default_nettype wire

//--- perf_event_sel.sv
/* Event selection
   picks one raw event per counter from its selector code */
`default_nettype none

`include "perf_cfg.svh"

module perf_event_sel (
  input  perf_event_pkg::event_sel_e   sel_i [`PERF_NUM_CNT],
  input  logic                         l1_icache_miss_i,
  input  logic                         l1_dcache_miss_i,
  input  logic                         itlb_miss_i,
  input  logic                         dtlb_miss_i,
  input  logic                         exception_i,
  input  logic                         eret_i,
  input  logic                         mispredict_i,
  input  logic                         sb_full_i,
  input  logic                         if_empty_i,
  input  logic                         stall_issue_i,
  input  logic [`PERF_NR_COMMIT-1:0]   commit_ack_i,
  input  perf_event_pkg::fu_t          commit_fu_i [`PERF_NR_COMMIT],
  output logic [`PERF_NUM_CNT-1:0]     event_o
);
  import perf_event_pkg::*;

  logic cm_load, cm_store, cm_branch, cm_int;

  // ---------------------------------------------------------------------------
  // commit ports reduced to flags, any acked port that matches
  // ---------------------------------------------------------------------------
  always_comb begin
    cm_load   = 1'b0;
    cm_store  = 1'b0;
    cm_branch = 1'b0;
    cm_int    = 1'b0;
    for (int unsigned j = 0; j < `PERF_NR_COMMIT; j++) begin
      if (commit_ack_i[j]) begin
        cm_load   |= (commit_fu_i[j] == LOAD);
        cm_store  |= (commit_fu_i[j] == STORE);
        cm_branch |= (commit_fu_i[j] == CTRL_FLOW);
        cm_int    |= (commit_fu_i[j] == ALU) || (commit_fu_i[j] == MULT);
      end
    end
  end

  // per counter mux
  always_comb begin
    for (int unsigned i = 0; i < `PERF_NUM_CNT; i++) begin
      case (sel_i[i])
        EV_NONE:        event_o[i] = 1'b0;
        EV_ICACHE_MISS: event_o[i] = l1_icache_miss_i;
        EV_DCACHE_MISS: event_o[i] = l1_dcache_miss_i;
        EV_ITLB_MISS:   event_o[i] = itlb_miss_i;
        EV_DTLB_MISS:   event_o[i] = dtlb_miss_i;
        EV_LOAD:        event_o[i] = cm_load;
        EV_STORE:       event_o[i] = cm_store;
        EV_EXCEPTION:   event_o[i] = exception_i;
        EV_ERET:        event_o[i] = eret_i;
        EV_BRANCH:      event_o[i] = cm_branch;
        EV_MISPREDICT:  event_o[i] = mispredict_i;
        EV_SB_FULL:     event_o[i] = sb_full_i;
        EV_IF_EMPTY:    event_o[i] = if_empty_i;
        EV_INT_OP:      event_o[i] = cm_int;
        EV_STALL_ISSUE: event_o[i] = stall_issue_i;
        default:        event_o[i] = 1'b0;   // unlisted code
      endcase
    end
  end

endmodule

`default_nettype wire

//--- perf_csr_access.sv
/* CSR access decode
   maps the address to register kind and counter index, muxes read data */
`default_nettype none

`include "perf_cfg.svh"

module perf_csr_access (
  input  perf_csr_pkg::csr_addr_t      addr_i,
  input  perf_csr_pkg::cnt_t           cnt_i [`PERF_NUM_CNT],
  input  perf_event_pkg::event_sel_e   sel_i [`PERF_NUM_CNT],
  output perf_csr_pkg::reg_kind_e      kind_o,
  output perf_csr_pkg::cnt_idx_t       idx_o,
  output perf_csr_pkg::csr_data_t      data_o
);
  import perf_csr_pkg::*;

  csr_addr_t off_lo, off_hi, off_ev;   // offsets into each range
  reg_kind_e kind;
  cnt_idx_t  idx;

  // below-base addresses wrap to large offsets and miss the range
  assign off_lo = addr_i - csr_addr_t'(`CSR_MHPMCOUNTER3);
  assign off_hi = addr_i - csr_addr_t'(`CSR_MHPMCOUNTER3H);
  assign off_ev = addr_i - csr_addr_t'(`CSR_MHPMEVENT3);

  // ---------------------------------------------------------------------------
  // address decode
  // ---------------------------------------------------------------------------
  always_comb begin
    kind = REG_NONE;
    idx  = '0;
    if (off_lo < csr_addr_t'(`PERF_NUM_CNT)) begin
      kind = REG_CNT_LO;
      idx  = cnt_idx_t'(off_lo);
    end else if (off_hi < csr_addr_t'(`PERF_NUM_CNT)) begin
      kind = REG_CNT_HI;
      idx  = cnt_idx_t'(off_hi);
    end else if (off_ev < csr_addr_t'(`PERF_NUM_CNT)) begin
      kind = REG_EVENT;
      idx  = cnt_idx_t'(off_ev);
    end
  end

  // ---------------------------------------------------------------------------
  // read mux, same cycle as the address
  // ---------------------------------------------------------------------------
  always_comb begin
    case (kind)
      REG_CNT_LO: data_o = cnt_i[idx][`PERF_XLEN-1:0];
      REG_CNT_HI: data_o = cnt_i[idx][`PERF_CNT_W-1:`PERF_XLEN];
      REG_EVENT:  data_o = csr_data_t'(sel_i[idx]);   // zero extended code
      default:    data_o = '0;                        // unmapped
    endcase
  end

  assign kind_o = kind;
  assign idx_o  = idx;

endmodule

`default_nettype wire

//--- perf_counter_bank.sv
/* Counter bank
   selector and counter registers with increment and CSR write update */
`default_nettype none

`include "perf_cfg.svh"

module perf_counter_bank (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         we_i,
  input  perf_csr_pkg::csr_data_t      data_i,
  input  perf_csr_pkg::reg_kind_e      kind_i,
  input  perf_csr_pkg::cnt_idx_t       idx_i,
  input  logic [`PERF_NUM_CNT-1:0]     event_i,
  input  logic                         debug_mode_i,
  input  logic [31:0]                  mcountinhibit_i,
  output perf_csr_pkg::cnt_t           cnt_o [`PERF_NUM_CNT],
  output perf_event_pkg::event_sel_e   sel_o [`PERF_NUM_CNT]
);
  import perf_csr_pkg::*;
  import perf_event_pkg::*;

  cnt_t       cnt_q [`PERF_NUM_CNT];
  cnt_t       cnt_d [`PERF_NUM_CNT];
  event_sel_e sel_q [`PERF_NUM_CNT];
  event_sel_e sel_d [`PERF_NUM_CNT];
  logic       count_en;

  // any write stalls all counting
  assign count_en = ~debug_mode_i & ~we_i;

  // ---------------------------------------------------------------------------
  // next state, write wins over counting
  // ---------------------------------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    sel_d = sel_q;
    for (int unsigned i = 0; i < `PERF_NUM_CNT; i++) begin
      if (count_en && event_i[i] && !mcountinhibit_i[i + `PERF_FIRST_CNT]) begin
        cnt_d[i] = cnt_q[i] + cnt_t'(1);
      end
    end
    if (we_i) begin
      case (kind_i)
        REG_CNT_LO: cnt_d[idx_i][`PERF_XLEN-1:0]           = data_i;  // low half only
        REG_CNT_HI: cnt_d[idx_i][`PERF_CNT_W-1:`PERF_XLEN] = data_i;
        REG_EVENT: begin
          sel_d[idx_i] = event_sel_e'(data_i[4:0]);
          cnt_d[idx_i] = '0;   // new selector restarts the count
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < `PERF_NUM_CNT; i++) begin
        cnt_q[i] <= '0;
        sel_q[i] <= EV_NONE;
      end
    end else begin
      cnt_q <= cnt_d;
      sel_q <= sel_d;
    end
  end

  assign cnt_o = cnt_q;
  assign sel_o = sel_q;

endmodule

`default_nettype wire

//--- perf_counters.sv
/* Hardware performance monitor
   six event counters behind a CSR port */
`default_nettype none

`include "perf_cfg.svh"

module perf_counters (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         debug_mode_i,
  // CSR port
  input  perf_csr_pkg::csr_addr_t      addr_i,
  input  logic                         we_i,
  input  perf_csr_pkg::csr_data_t      data_i,
  output perf_csr_pkg::csr_data_t      data_o,
  input  logic [31:0]                  mcountinhibit_i,
  // raw events
  input  logic                         l1_icache_miss_i,
  input  logic                         l1_dcache_miss_i,
  input  logic                         itlb_miss_i,
  input  logic                         dtlb_miss_i,
  input  logic                         exception_i,
  input  logic                         eret_i,
  input  logic                         mispredict_i,
  input  logic                         sb_full_i,
  input  logic                         if_empty_i,
  input  logic                         stall_issue_i,
  // commit stage
  input  logic [`PERF_NR_COMMIT-1:0]   commit_ack_i,
  input  perf_event_pkg::fu_t          commit_fu_i [`PERF_NR_COMMIT]
);
  import perf_csr_pkg::*;
  import perf_event_pkg::*;

  reg_kind_e                 kind;
  cnt_idx_t                  idx;
  cnt_t                      cnt [`PERF_NUM_CNT];
  event_sel_e                sel [`PERF_NUM_CNT];
  logic [`PERF_NUM_CNT-1:0]  events;

  perf_event_sel u_event_sel (
    .sel_i            (sel),
    .l1_icache_miss_i (l1_icache_miss_i),
    .l1_dcache_miss_i (l1_dcache_miss_i),
    .itlb_miss_i      (itlb_miss_i),
    .dtlb_miss_i      (dtlb_miss_i),
    .exception_i      (exception_i),
    .eret_i           (eret_i),
    .mispredict_i     (mispredict_i),
    .sb_full_i        (sb_full_i),
    .if_empty_i       (if_empty_i),
    .stall_issue_i    (stall_issue_i),
    .commit_ack_i     (commit_ack_i),
    .commit_fu_i      (commit_fu_i),
    .event_o          (events)
  );

  perf_csr_access u_csr_access (
    .addr_i (addr_i),
    .cnt_i  (cnt),
    .sel_i  (sel),
    .kind_o (kind),
    .idx_o  (idx),
    .data_o (data_o)
  );

  perf_counter_bank u_counter_bank (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .we_i            (we_i),
    .data_i          (data_i),
    .kind_i          (kind),
    .idx_i           (idx),
    .event_i         (events),
    .debug_mode_i    (debug_mode_i),
    .mcountinhibit_i (mcountinhibit_i),
    .cnt_o           (cnt),
    .sel_o           (sel)
  );

endmodule

`default_nettype wire

//--- perf_counters_props.sv
/* Assertions for the performance monitor
   unmapped reads, debug freeze and selector write clear */
`default_nettype none

`include "perf_cfg.svh"

module perf_counters_props (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     debug_mode_i,
  input logic                     we_i,
  input perf_csr_pkg::csr_addr_t  addr_i,
  input perf_csr_pkg::reg_kind_e  kind_i,
  input perf_csr_pkg::cnt_idx_t   idx_i,
  input perf_csr_pkg::csr_data_t  rdata_i,
  input perf_csr_pkg::cnt_t       cnt_i [`PERF_NUM_CNT]
);
  import perf_csr_pkg::*;

  logic mapped;   // address hits one of the three ranges

  function automatic logic in_range(input csr_addr_t addr, input csr_addr_t base);
    return (addr >= base) && (addr < base + csr_addr_t'(`PERF_NUM_CNT));
  endfunction

  assign mapped = in_range(addr_i, `CSR_MHPMCOUNTER3) ||
                  in_range(addr_i, `CSR_MHPMCOUNTER3H) ||
                  in_range(addr_i, `CSR_MHPMEVENT3);

  unmapped_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !mapped |-> rdata_i == '0)
    else $error("unmapped address read back nonzero data");

  // per counter checks
  for (genvar g = 0; g < `PERF_NUM_CNT; g++) begin : g_cnt
    debug_freeze: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (debug_mode_i && !we_i) |=> $stable(cnt_i[g]))
      else $error("counter %0d changed in debug mode", g);

    sel_write_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (we_i && kind_i == REG_EVENT && idx_i == g) |=> cnt_i[g] == '0)
      else $error("counter %0d not cleared by selector write", g);
  end

endmodule

bind perf_counters perf_counters_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .debug_mode_i (debug_mode_i),
  .we_i         (we_i),
  .addr_i       (addr_i),
  .kind_i       (kind),
  .idx_i        (idx),
  .rdata_i      (data_o),
  .cnt_i        (cnt)
);

`default_nettype wire

//--- tb_perf_counters.sv
/* Testbench for the performance monitor
   directed tests over the CSR map, counting, gating and commit events */
`default_nettype none

`include "perf_cfg.svh"

module tb_perf_counters;
  import perf_event_pkg::*;

  localparam int MAX_CYCLES = 2000;  // tests need about 250 cycles

  logic                       clk_i;
  logic                       rst_ni;
  logic                       debug_mode_i;
  logic                       we_i;
  logic [11:0]                addr_i;
  logic [31:0]                data_i;
  logic [31:0]                data_o;
  logic [31:0]                mcountinhibit_i;
  logic                       l1_icache_miss_i, l1_dcache_miss_i, itlb_miss_i, dtlb_miss_i;
  logic                       exception_i, eret_i, mispredict_i;
  logic                       sb_full_i, if_empty_i, stall_issue_i;
  logic [`PERF_NR_COMMIT-1:0] commit_ack_i;
  fu_t                        commit_fu_i [`PERF_NR_COMMIT];
  int                         errors = 0;
  int                         test_base = 0;
  int                         cycles = 0;
  integer                     seed;

  perf_counters u_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .debug_mode_i     (debug_mode_i),
    .addr_i           (addr_i),
    .we_i             (we_i),
    .data_i           (data_i),
    .data_o           (data_o),
    .mcountinhibit_i  (mcountinhibit_i),
    .l1_icache_miss_i (l1_icache_miss_i),
    .l1_dcache_miss_i (l1_dcache_miss_i),
    .itlb_miss_i      (itlb_miss_i),
    .dtlb_miss_i      (dtlb_miss_i),
    .exception_i      (exception_i),
    .eret_i           (eret_i),
    .mispredict_i     (mispredict_i),
    .sb_full_i        (sb_full_i),
    .if_empty_i       (if_empty_i),
    .stall_issue_i    (stall_issue_i),
    .commit_ack_i     (commit_ack_i),
    .commit_fu_i      (commit_fu_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  task automatic step();
    @(posedge clk_i);
    #1;  // drive just after the edge
  endtask

  function automatic logic rand_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic idle_events();
    {l1_icache_miss_i, l1_dcache_miss_i, itlb_miss_i, dtlb_miss_i} = '0;
    {exception_i, eret_i, mispredict_i} = '0;
    {sb_full_i, if_empty_i, stall_issue_i} = '0;
    commit_ack_i = '0;
    for (int j = 0; j < `PERF_NR_COMMIT; j++) begin
      commit_fu_i[j] = NONE;
    end
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    step();
    addr_i = addr;
    data_i = data;
    we_i   = 1'b1;
    step();
    we_i   = 1'b0;
    addr_i = 12'h000;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    step();
    addr_i = addr;
    #2 data = data_o;  // comb read settles well before the next edge
  endtask

  task automatic read_cnt(input int idx, output logic [63:0] value);
    logic [31:0] lo;
    logic [31:0] hi;
    csr_read(`CSR_MHPMCOUNTER3 + idx, lo);
    csr_read(`CSR_MHPMCOUNTER3H + idx, hi);
    value = {hi, lo};
  endtask

  task automatic report_test(input string name);
    $display("%-14s %s, %0d errors", name, (errors == test_base) ? "ok" : "FAILED",
             errors - test_base);
    test_base = errors;
  endtask

  // ---------------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------------
  task automatic test_reset_map();
    logic [63:0] v;
    logic [31:0] rd;
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      read_cnt(i, v);
      check($sformatf("mhpmcounter%0d", i + 3), 64'd0, v);
      csr_read(`CSR_MHPMEVENT3 + i, rd);
      check($sformatf("mhpmevent%0d", i + 3), 64'd0, rd);
    end
    csr_read(12'h000, rd);
    check("data_o @000", 64'd0, rd);
    csr_read(12'hB09, rd);  // one past the last counter
    check("data_o @B09", 64'd0, rd);
    csr_read(12'h329, rd);
    check("data_o @329", 64'd0, rd);
  endtask

  task automatic test_select_count();
    int          k;
    logic [31:0] rd;
    k = 0;
    csr_write(`CSR_MHPMEVENT3, EV_ICACHE_MISS);
    for (int n = 0; n < 30; n++) begin
      step();
      l1_icache_miss_i = rand_bit();
      k += l1_icache_miss_i;
    end
    step();
    l1_icache_miss_i = 1'b0;
    csr_read(`CSR_MHPMCOUNTER3, rd);
    check("mhpmcounter3", k, rd);
    csr_write(`CSR_MHPMEVENT3, EV_ICACHE_MISS);  // same code, count restarts
    csr_read(`CSR_MHPMCOUNTER3, rd);
    check("mhpmcounter3 cleared", 64'd0, rd);
    csr_read(`CSR_MHPMEVENT3, rd);
    check("mhpmevent3", 64'd1, rd);
  endtask

  task automatic test_gating();
    logic [31:0] rd;
    step();
    debug_mode_i     = 1'b1;
    l1_icache_miss_i = 1'b1;
    repeat (3) step();
    debug_mode_i    = 1'b0;
    mcountinhibit_i = 32'h1 << `PERF_FIRST_CNT;  // inhibit counter 3
    repeat (3) step();
    mcountinhibit_i = '0;
    we_i            = 1'b1;  // write to an unmapped address
    repeat (3) step();
    we_i = 1'b0;
    step();  // one ungated cycle
    l1_icache_miss_i = 1'b0;
    csr_read(`CSR_MHPMCOUNTER3, rd);
    check("mhpmcounter3 gated", 64'd1, rd);
  endtask

  task automatic test_commit();
    int          exp [4];
    logic [3:0]  hit;  // load, store, branch, integer
    logic [2:0]  fu;
    logic [63:0] v;
    csr_write(`CSR_MHPMEVENT3 + 0, EV_LOAD);
    csr_write(`CSR_MHPMEVENT3 + 1, EV_STORE);
    csr_write(`CSR_MHPMEVENT3 + 2, EV_BRANCH);
    csr_write(`CSR_MHPMEVENT3 + 3, EV_INT_OP);
    for (int c = 0; c < 4; c++) begin
      exp[c] = 0;
    end
    for (int n = 0; n < 40; n++) begin
      step();
      hit = '0;
      for (int j = 0; j < `PERF_NR_COMMIT; j++) begin
        commit_ack_i[j] = rand_bit();
        fu = $unsigned($random(seed)) % 6;
        commit_fu_i[j] = fu_t'(fu);
        if (commit_ack_i[j]) begin
          case (commit_fu_i[j])
            LOAD:      hit[0] = 1'b1;
            STORE:     hit[1] = 1'b1;
            CTRL_FLOW: hit[2] = 1'b1;
            ALU, MULT: hit[3] = 1'b1;
            default:   ;
          endcase
        end
      end
      for (int c = 0; c < 4; c++) begin
        exp[c] += hit[c];
      end
    end
    step();
    idle_events();
    for (int c = 0; c < 4; c++) begin
      read_cnt(c, v);
      check($sformatf("mhpmcounter%0d", c + 3), exp[c], v);
    end
  endtask

  task automatic test_cnt_write();
    logic [63:0] v;
    csr_write(`CSR_MHPMEVENT3 + 4, EV_EXCEPTION);
    csr_write(`CSR_MHPMCOUNTER3 + 4, 32'hFFFF_FFFF);
    csr_write(`CSR_MHPMCOUNTER3H + 4, 32'h0000_0012);
    read_cnt(4, v);
    check("mhpmcounter7 written", 64'h12_FFFF_FFFF, v);
    step();
    exception_i = 1'b1;
    step();
    exception_i = 1'b0;
    read_cnt(4, v);
    check("mhpmcounter7 carry", 64'h13_0000_0000, v);
    csr_write(`CSR_MHPMCOUNTER3 + 4, 32'h0000_0005);  // upper half stays
    read_cnt(4, v);
    check("mhpmcounter7 low write", 64'h13_0000_0005, v);
  endtask

  task automatic test_independent();
    int          exp [`PERF_NUM_CNT];
    logic [63:0] v;
    logic [31:0] rd;
    csr_write(`CSR_MHPMEVENT3 + 0, EV_DCACHE_MISS);
    csr_write(`CSR_MHPMEVENT3 + 1, EV_ITLB_MISS);
    csr_write(`CSR_MHPMEVENT3 + 2, EV_DTLB_MISS);
    csr_write(`CSR_MHPMEVENT3 + 3, EV_MISPREDICT);
    csr_write(`CSR_MHPMEVENT3 + 4, EV_STALL_ISSUE);
    csr_write(`CSR_MHPMEVENT3 + 5, 32'd13);  // not in the event list
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      exp[i] = 0;
    end
    for (int n = 0; n < 40; n++) begin
      step();
      {l1_icache_miss_i, l1_dcache_miss_i, itlb_miss_i, dtlb_miss_i, exception_i} = $random(seed);
      {eret_i, mispredict_i, sb_full_i, if_empty_i, stall_issue_i} = $random(seed);
      exp[0] += l1_dcache_miss_i;
      exp[1] += itlb_miss_i;
      exp[2] += dtlb_miss_i;
      exp[3] += mispredict_i;
      exp[4] += stall_issue_i;
    end
    step();
    idle_events();
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      read_cnt(i, v);
      check($sformatf("mhpmcounter%0d", i + 3), exp[i], v);
    end
    csr_read(`CSR_MHPMEVENT3 + 5, rd);
    check("mhpmevent8", 64'd13, rd);
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    seed            = 30;
    rst_ni          = 1'b0;
    debug_mode_i    = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    data_i          = '0;
    mcountinhibit_i = '0;
    idle_events();
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    test_reset_map();
    report_test("reset_map");
    test_select_count();
    report_test("select_count");
    test_gating();
    report_test("gating");
    test_commit();
    report_test("commit");
    test_cnt_write();
    report_test("cnt_write");
    test_independent();
    report_test("independent");

    $display("Summary: 6 tests, %0d errors, %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
perf_event_pkg.sv
perf_csr_pkg.sv
perf_event_sel.sv
perf_csr_access.sv
perf_counter_bank.sv
perf_counters.sv
perf_counters_props.sv
tb_perf_counters.sv

//--- Bender.yml
package:
  name: perf_counters

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - perf_event_pkg.sv
      - perf_csr_pkg.sv
      - perf_event_sel.sv
      - perf_csr_access.sv
      - perf_counter_bank.sv
      - perf_counters.sv
  - target: test
    include_dirs:
      - .
    files:
      - perf_counters_props.sv
      - tb_perf_counters.sv
